// File: rtl/rename_pkg.sv
/*
 * Rename stage shared definitions
 * Physical register tag type, lane count and the widths derived from them
 */
package rename_pkg;

	// ==============================
	// Lane and register file limits
	// ==============================

	// One rename lane per register bank, four of each
	localparam int NLANES = 4;

	// Largest register file a tag can address
	localparam int PREGS_MAX = 256;

	// Tag width and its split into a bank select and an index within the bank
	localparam int TAG_W = $clog2(PREGS_MAX);
	localparam int BANK_SEL_W = $clog2(NLANES);
	localparam int BANK_IDX_W = TAG_W - BANK_SEL_W;

	// ==============================
	// Types
	// ==============================

	// Physical register tag, the bank sits in the top bits
	typedef logic [TAG_W-1:0] pregno_t;

	// Offset of a tag within its own bank
	typedef logic [BANK_IDX_W-1:0] bank_idx_t;

	// One bit per lane, for requests and per-lane strobes
	typedef logic [NLANES-1:0] lane_mask_t;

endpackage

// File: rtl/free_fifo_if.sv
/*
 * Link between one register bank's scanner, its ready-tag FIFO
 * and the matching allocator lane
 */
`timescale 1ns/10ps

interface free_fifo_if;
	import rename_pkg::*;

	// Refill side, the scanner pushes the lowest pending tag of the bank
	logic refill;
	pregno_t refill_tag;
	logic full;

	// Grant side, the allocator takes the oldest ready tag
	pregno_t head_tag;
	logic empty;
	logic pop;

	// Producer only sees whether it may push
	modport scanner (output refill, output refill_tag, input full);

	// The FIFO owns the occupancy flags and the head entry
	modport fifo (
		input refill, input refill_tag, input pop,
		output full, output head_tag, output empty
	);

	// Consumer pops while the head is valid
	modport allocator (input head_tag, input empty, output pop);

endinterface

// File: rtl/free_list_scanner.sv
/*
 * Pending-free bitmap of the physical register file
 * Collects single and flush frees, then refills every bank FIFO
 * with the lowest pending tag of that bank once per cycle
 */
`timescale 1ns/10ps

module free_list_scanner #(
	parameter int PREGS = rename_pkg::PREGS_MAX
) (
	input logic clk,
	input logic rst,
	input logic en,
	input rename_pkg::lane_mask_t free_valid,
	input rename_pkg::pregno_t [rename_pkg::NLANES-1:0] free_tag,
	input logic [PREGS-1:0] flush_free,
	free_fifo_if.scanner bank [rename_pkg::NLANES]
);
	import rename_pkg::*;

	// Each bank owns this many consecutive tags
	localparam int BANK_SIZE = PREGS / NLANES;

	// Tags waiting to be pushed into their bank FIFO
	logic [PREGS-1:0] pending;

	// Decoded single frees from the retire lanes
	logic [PREGS-1:0] free_mask;

	// Tags leaving the bitmap for a FIFO this cycle
	logic [PREGS-1:0] take_mask;

	// Per-bank refill state
	lane_mask_t bank_full;
	lane_mask_t bank_any;
	lane_mask_t take;
	pregno_t take_tag [NLANES];

	// Priority encoder, the lowest set bit of one bank slice wins
	function automatic bank_idx_t lowest_set(input logic [BANK_SIZE-1:0] slice);
		bank_idx_t pos;
		pos = '0;
		// Scan downward so the last hit is the lowest index
		for (int i = BANK_SIZE - 1; i >= 0; i--) begin
			if (slice[i]) begin
				pos = bank_idx_t'(i);
			end
		end
		return pos;
	endfunction

	// ==============================
	// Per-bank refill
	// ==============================

	for (genvar b = 0; b < NLANES; b++) begin : g_bank
		// First tag of this bank
		localparam pregno_t BASE = pregno_t'(b * BANK_SIZE);
		logic [BANK_SIZE-1:0] slice;

		assign slice = pending[b*BANK_SIZE +: BANK_SIZE];
		assign bank_any[b] = |slice;
		assign bank_full[b] = bank[b].full;

		// A full FIFO leaves this bank's pending bits untouched
		assign take[b] = en & bank_any[b] & ~bank_full[b];
		assign take_tag[b] = BASE + pregno_t'(lowest_set(slice));

		assign bank[b].refill = take[b];
		assign bank[b].refill_tag = take_tag[b];
	end

	// ==============================
	// Bitmap update
	// ==============================

	// Turn the lane tags into bitmap masks
	always_comb begin
		free_mask = '0;
		take_mask = '0;
		for (int l = 0; l < NLANES; l++) begin
			if (free_valid[l]) begin
				free_mask[free_tag[l]] = 1'b1;
			end
			if (take[l]) begin
				take_mask[take_tag[l]] = 1'b1;
			end
		end
	end

	// Every register starts out free and pending, so the FIFOs fill after reset.
	// Frees are merged on the same edge that the refilled bits are cleared,
	// which makes a freed tag refillable from the next cycle on
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '1;
		end else if (en) begin
			pending <= (pending & ~take_mask) | free_mask | flush_free;
		end
	end

endmodule

// File: rtl/free_tag_fifo.sv
/*
 * Circular FIFO of ready physical register tags for one bank
 * Occupancy count gives full and empty, the oldest entry is the head
 */
`timescale 1ns/10ps

module free_tag_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic en,
	free_fifo_if.fifo port
);
	import rename_pkg::*;

	// Depth is a power of two, so the pointers wrap by themselves
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [PTR_W:0] count_t;

	// Tag storage
	pregno_t mem [FIFO_DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;

	// Qualified transfers
	logic do_push;
	logic do_pop;

	// ==============================
	// Flags and head
	// ==============================

	assign port.full = count == count_t'(FIFO_DEPTH);
	assign port.empty = count == '0;

	// Head is only meaningful while the FIFO holds something
	assign port.head_tag = mem[rd_ptr];

	// A push and a pop may land on the same edge
	assign do_push = en & port.refill & ~port.full;
	assign do_pop = en & port.pop & ~port.empty;

	// ==============================
	// Storage and pointers
	// ==============================

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= port.refill_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Head moves to the next entry one cycle after the pop
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: rtl/rename_allocator.sv
/*
 * Tag allocator for the four rename lanes
 * Grants bank FIFO heads, raises a group stall and keeps the
 * availability bitmap that the reorder buffer records
 */
`timescale 1ns/10ps

module rename_allocator #(
	parameter int PREGS = rename_pkg::PREGS_MAX
) (
	input logic clk,
	input logic rst,
	input logic en,
	input rename_pkg::lane_mask_t alloc,
	input rename_pkg::lane_mask_t free_valid,
	input rename_pkg::pregno_t [rename_pkg::NLANES-1:0] free_tag,
	input logic [PREGS-1:0] flush_free,
	free_fifo_if.allocator lane [rename_pkg::NLANES],
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0] alloc_tag,
	output logic stall,
	output logic [PREGS-1:0] avail
);
	import rename_pkg::*;

	// Lane view of the bank FIFOs
	lane_mask_t lane_empty;

	// Lanes that take a tag this cycle
	lane_mask_t grant;

	// Bitmap forms of the grants and the single frees
	logic [PREGS-1:0] grant_mask;
	logic [PREGS-1:0] free_mask;

	// ==============================
	// Grant and stall
	// ==============================

	for (genvar l = 0; l < NLANES; l++) begin : g_lane
		assign lane_empty[l] = lane[l].empty;
		// Each lane is served only from its own bank
		assign alloc_tag[l] = lane[l].head_tag;
		assign lane[l].pop = grant[l];
	end

	// Any requesting lane with a dry bank holds up the whole group
	assign stall = |(alloc & lane_empty);

	// Without a stall every requesting lane is granted together
	assign grant = alloc & {NLANES{en & ~stall}};

	// ==============================
	// Availability bitmap
	// ==============================

	always_comb begin
		grant_mask = '0;
		free_mask = '0;
		for (int l = 0; l < NLANES; l++) begin
			if (grant[l]) begin
				grant_mask[alloc_tag[l]] = 1'b1;
			end
			if (free_valid[l]) begin
				free_mask[free_tag[l]] = 1'b1;
			end
		end
	end

	// The whole register file is available out of reset.
	// Granted tags drop and freed tags rise one cycle after the event.
	// A live tag can never be granted and freed on the same edge,
	// so the order of clear and set does not matter for legal traffic
	always_ff @(posedge clk) begin
		if (rst) begin
			avail <= '1;
		end else if (en) begin
			avail <= (avail & ~grant_mask) | free_mask | flush_free;
		end
	end

endmodule

// File: rtl/reg_renamer.sv
/*
 * Physical register free list of the rename stage
 * Pending-free scanner, one ready-tag FIFO per bank and the lane allocator
 */
`timescale 1ns/10ps

module reg_renamer #(
	parameter int PREGS = rename_pkg::PREGS_MAX,
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic en,
	input rename_pkg::lane_mask_t alloc,
	input rename_pkg::lane_mask_t free_valid,
	input rename_pkg::pregno_t [rename_pkg::NLANES-1:0] free_tag,
	input logic [PREGS-1:0] flush_free,
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0] alloc_tag,
	output logic stall,
	output logic [PREGS-1:0] avail
);
	import rename_pkg::*;

	// One link per bank, shared by the scanner, the FIFO and the allocator
	free_fifo_if bank_if [NLANES] ();

	// ==============================
	// Producer
	// ==============================

	// Frees are seen here and in the allocator on the same edge
	free_list_scanner #(
		.PREGS(PREGS)
	) scanner_i (
		.clk(clk),
		.rst(rst),
		.en(en),
		.free_valid(free_valid),
		.free_tag(free_tag),
		.flush_free(flush_free),
		.bank(bank_if)
	);

	// Ready-tag buffer per bank
	for (genvar b = 0; b < NLANES; b++) begin : g_fifo
		free_tag_fifo #(
			.FIFO_DEPTH(FIFO_DEPTH)
		) fifo_i (
			.clk(clk),
			.rst(rst),
			.en(en),
			.port(bank_if[b])
		);
	end

	// ==============================
	// Consumer
	// ==============================

	// Grants, stall and the availability bitmap
	rename_allocator #(
		.PREGS(PREGS)
	) allocator_i (
		.clk(clk),
		.rst(rst),
		.en(en),
		.alloc(alloc),
		.free_valid(free_valid),
		.free_tag(free_tag),
		.flush_free(flush_free),
		.lane(bank_if),
		.alloc_tag(alloc_tag),
		.stall(stall),
		.avail(avail)
	);

endmodule

// File: tb/reg_renamer_assertions.sv
/*
 * Bound checker for the rename free list
 * Shadow in-use bitmap, grant, availability, stall and hold assertions
 */
`timescale 1ns/10ps

module reg_renamer_assertions #(
	parameter int PREGS = rename_pkg::PREGS_MAX
) (
	input logic clk,
	input logic rst,
	input logic en,
	input rename_pkg::lane_mask_t alloc,
	input rename_pkg::lane_mask_t free_valid,
	input rename_pkg::pregno_t [rename_pkg::NLANES-1:0] free_tag,
	input logic [PREGS-1:0] flush_free,
	input rename_pkg::pregno_t [rename_pkg::NLANES-1:0] alloc_tag,
	input logic stall,
	input logic [PREGS-1:0] avail
);
	import rename_pkg::*;

	localparam int BANK_SIZE = PREGS / NLANES;
	localparam int STALL_LIMIT = BANK_SIZE + 3;

	// Sticky, polled by the testbench
	bit failed = 1'b0;

	// Tags held by renamed instructions
	logic [PREGS-1:0] in_use;
	logic [PREGS-1:0] grant_mask;
	logic [PREGS-1:0] free_mask;

	// High while every requesting lane still has a free tag in its bank
	logic banks_have_free;
	int stall_run;

	always_comb begin
		grant_mask = '0;
		free_mask = '0;
		banks_have_free = 1'b1;
		for (int l = 0; l < NLANES; l++) begin
			if (en && alloc[l] && !stall) begin
				grant_mask[alloc_tag[l]] = 1'b1;
			end
			if (free_valid[l]) begin
				free_mask[free_tag[l]] = 1'b1;
			end
			if (alloc[l] && in_use[l*BANK_SIZE +: BANK_SIZE] == '1) begin
				banks_have_free = 1'b0;
			end
		end
	end

	// ==============================
	// Shadow model
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			in_use <= '0;
			stall_run <= 0;
		end else if (en) begin
			in_use <= (in_use | grant_mask) & ~free_mask & ~flush_free;
			stall_run <= (stall && banks_have_free) ? stall_run + 1 : 0;
		end
	end

	// ==============================
	// Properties
	// ==============================

	for (genvar l = 0; l < NLANES; l++) begin : g_lane
		// A grant comes from the lane's own bank and was available
		a_grant_bank: assert property (@(posedge clk) disable iff (rst)
			en && alloc[l] && !stall |-> int'(alloc_tag[l]) / BANK_SIZE == l)
		else begin
			$error("Error at %0t: alloc_tag[%0d] got %h expected a tag of bank %0d",
				$time, l, $sampled(alloc_tag[l]), l);
			failed = 1'b1;
		end
		a_grant_avail: assert property (@(posedge clk) disable iff (rst)
			en && alloc[l] && !stall |-> avail[alloc_tag[l]])
		else begin
			$error("Error at %0t: avail[%h] got 0 expected 1", $time, $sampled(alloc_tag[l]));
			failed = 1'b1;
		end
	end

	a_avail_model: assert property (@(posedge clk) disable iff (rst) avail == ~in_use)
	else begin
		$error("Error at %0t: avail got %h expected %h", $time, $sampled(avail), ~$sampled(in_use));
		failed = 1'b1;
	end

	// Nothing is granted in a stalled cycle
	a_stall_no_grant: assert property (@(posedge clk) disable iff (rst)
		stall |=> ($past(avail) & ~avail) == '0)
	else begin
		$error("Error at %0t: avail got %h expected no cleared bit of %h", $time,
			$sampled(avail), $past(avail));
		failed = 1'b1;
	end

	a_stall_idle: assert property (@(posedge clk) disable iff (rst) alloc == '0 |-> !stall)
	else begin
		$error("Error at %0t: stall got 1 expected 0", $time);
		failed = 1'b1;
	end

	a_stall_live: assert property (@(posedge clk) disable iff (rst) stall_run <= STALL_LIMIT)
	else begin
		$error("Error at %0t: stall got %0d cycles high expected at most %0d", $time,
			$sampled(stall_run), STALL_LIMIT);
		failed = 1'b1;
	end

	a_hold: assert property (@(posedge clk) disable iff (rst) !en |=> avail == $past(avail))
	else begin
		$error("Error at %0t: avail got %h expected %h", $time, $sampled(avail), $past(avail));
		failed = 1'b1;
	end

endmodule

bind reg_renamer reg_renamer_assertions #(
	.PREGS(PREGS)
) assertions_i (
	.clk(clk),
	.rst(rst),
	.en(en),
	.alloc(alloc),
	.free_valid(free_valid),
	.free_tag(free_tag),
	.flush_free(flush_free),
	.alloc_tag(alloc_tag),
	.stall(stall),
	.avail(avail)
);

// File: tb/reg_renamer_tb.sv
/*
 * Testbench for the rename free list
 * Clock, reset, LCG stimulus in five phases, failure monitor and watchdog
 */
`timescale 1ns/10ps

module reg_renamer_tb;
	import rename_pkg::*;

	localparam int PREGS = 256;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int DRAIN_CYCLES = 80;
	localparam int FREE_CYCLES = 60;
	localparam int FLUSH_CYCLES = 4;
	localparam int HOLD_CYCLES = 10;
	localparam int MIXED_CYCLES = 300;
	localparam int END_CYCLES = 3;
	localparam int TOTAL_CYCLES = RESET_CYCLES + DRAIN_CYCLES + FREE_CYCLES + FLUSH_CYCLES
		+ HOLD_CYCLES + MIXED_CYCLES + END_CYCLES;
	localparam int MARGIN_CYCLES = 50;

	logic clk;
	logic rst;
	logic en;
	lane_mask_t alloc;
	lane_mask_t free_valid;
	pregno_t [NLANES-1:0] free_tag;
	logic [PREGS-1:0] flush_free;
	pregno_t [NLANES-1:0] alloc_tag;
	logic stall;
	logic [PREGS-1:0] avail;

	logic [31:0] seed;

	// Tags granted and not yet handed back
	pregno_t granted [$];

	reg_renamer reg_renamer_i (
		.clk(clk),
		.rst(rst),
		.en(en),
		.alloc(alloc),
		.free_valid(free_valid),
		.free_tag(free_tag),
		.flush_free(flush_free),
		.alloc_tag(alloc_tag),
		.stall(stall),
		.avail(avail)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// Random helpers
	// ==============================

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Removes one recorded grant at random
	function automatic pregno_t take_granted();
		int idx;
		pregno_t tag;
		idx = int'(32'(next_random() >> 16) % 32'(granted.size()));
		tag = granted[idx];
		granted.delete(idx);
		return tag;
	endfunction

	// Roughly half of the live tags go back in one flush
	function automatic logic [PREGS-1:0] flush_subset();
		logic [PREGS-1:0] mask;
		pregno_t kept [$];
		logic [31:0] r;
		mask = '0;
		foreach (granted[i]) begin
			r = next_random();
			if (r[31]) begin
				mask[granted[i]] = 1'b1;
			end else begin
				kept.push_back(granted[i]);
			end
		end
		granted = kept;
		return mask;
	endfunction

	function automatic logic [PREGS-1:0] random_wide();
		logic [PREGS-1:0] v;
		for (int w = 0; w < PREGS / 32; w++) begin
			v[w*32 +: 32] = next_random();
		end
		return v;
	endfunction

	// Each lane frees a live tag with probability chance/16
	task automatic build_frees(input logic [3:0] chance, output lane_mask_t fv,
		output pregno_t [NLANES-1:0] ft);
		logic [31:0] r;
		fv = '0;
		ft = '0;
		for (int l = 0; l < NLANES; l++) begin
			r = next_random();
			if (r[31:28] < chance && granted.size() > 0) begin
				fv[l] = 1'b1;
				ft[l] = take_granted();
			end
		end
	endtask

	// Drives one cycle on the falling edge, then records the grants just before the rise
	task automatic run_cycle(input logic en_in, input lane_mask_t alloc_in,
		input lane_mask_t fv_in, input pregno_t [NLANES-1:0] ft_in,
		input logic [PREGS-1:0] flush_in);
		@(negedge clk);
		en = en_in;
		alloc = alloc_in;
		free_valid = fv_in;
		free_tag = ft_in;
		flush_free = flush_in;
		#(CLK_PERIOD / 2 - 1);
		if (en && !stall) begin
			for (int l = 0; l < NLANES; l++) begin
				if (alloc[l]) begin
					granted.push_back(alloc_tag[l]);
				end
			end
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		lane_mask_t fv;
		pregno_t [NLANES-1:0] ft;
		logic [PREGS-1:0] fl;
		logic [31:0] r;
		seed = 32'hbd0c_b1f0;
		rst = 1'b1;
		en = 1'b0;
		alloc = '0;
		free_valid = '0;
		free_tag = '0;
		flush_free = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// All lanes request until every bank is dry and stall holds
		repeat (DRAIN_CYCLES) run_cycle(1'b1, '1, '0, '0, '0);

		// Single frees of live tags
		repeat (FREE_CYCLES) begin
			build_frees(4'd8, fv, ft);
			run_cycle(1'b1, '0, fv, ft, '0);
		end

		// One flush, then let the banks refill
		fl = flush_subset();
		run_cycle(1'b1, '0, '0, '0, fl);
		repeat (FLUSH_CYCLES - 1) run_cycle(1'b1, '0, '0, '0, '0);

		// Busy inputs with en low must change nothing
		repeat (HOLD_CYCLES) begin
			r = next_random();
			for (int l = 0; l < NLANES; l++) begin
				ft[l] = pregno_t'(next_random() >> 24);
			end
			run_cycle(1'b0, r[27:24], r[23:20], ft, random_wide());
		end

		// Mixed traffic with the odd disabled cycle and flush
		repeat (MIXED_CYCLES) begin
			r = next_random();
			if (r[31:29] == 3'd0) begin
				run_cycle(1'b0, r[27:24], '0, '0, '0);
			end else begin
				build_frees(4'd4, fv, ft);
				fl = (r[23:19] == 5'd0) ? flush_subset() : '0;
				run_cycle(1'b1, r[27:24], fv, ft, fl);
			end
		end

		repeat (END_CYCLES - 1) run_cycle(1'b1, '0, '0, '0, '0);
		@(negedge clk);
		if (reg_renamer_i.assertions_i.failed) begin
			$display("Errors found");
			$fatal(1, "An assertion failed during the run");
		end else begin
			$display("No errors");
			$finish;
		end
	end

	// Stops at the first assertion failure
	always @(negedge clk) begin
		if (reg_renamer_i.assertions_i.failed) begin
			$display("Errors found");
			$fatal(1, "An assertion in the bound checker failed");
		end
	end

	initial begin
		#((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Errors found");
		$fatal(1, "Timeout, the stimulus did not finish within the expected run time");
	end

endmodule

// File: flist.f
rtl/rename_pkg.sv
rtl/free_fifo_if.sv
rtl/free_list_scanner.sv
rtl/free_tag_fifo.sv
rtl/rename_allocator.sv
rtl/reg_renamer.sv
tb/reg_renamer_assertions.sv
tb/reg_renamer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= reg_renamer_tb
RTL_TOP ?= reg_renamer
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
SIM_ARGS ?= +verilator+error+limit+100
LOG ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^No errors$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
